//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= soc_fabric.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	elif grep -q "All tests passed!" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                clk,
  input  logic                i_arst_n,
  input  soc_pkg::bus_req_t   i_req,
  input  logic                i_req_empty,
  input  logic                i_slot_free,
  output logic                o_pop,
  output soc_pkg::slave_req_t o_mem_req,
  output soc_pkg::slave_req_t o_io_req
);

  logic is_io;

  // Only pop once a response slot is reserved downstream
  assign o_pop = !i_req_empty && i_slot_free;
  assign is_io = (i_req.addr[soc_pkg::ADDR_W-1 -: 2] == soc_pkg::IO_REGION);

  always_comb
  begin
    o_mem_req.valid = o_pop && !is_io;
    o_mem_req.req   = i_req;
    o_io_req.valid  = o_pop && is_io;
    o_io_req.req    = i_req;
  end

  a_one_slave: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_mem_req.valid && o_io_req.valid))
    else $error("bus_decoder: request dispatched to both slaves");

endmodule

`default_nettype wire

//--- data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int MEM_AW = 8
) (
  input  logic                clk,
  input  logic                i_arst_n,
  input  soc_pkg::slave_req_t i_req,
  output soc_pkg::slave_rsp_t o_rsp
);

  localparam int WORDS = 2 ** MEM_AW;

  logic [soc_pkg::DATA_W-1:0] mem [WORDS];
  logic [MEM_AW-1:0]          idx;
  logic                       rsp_valid;
  logic [soc_pkg::DATA_W-1:0] rsp_data;

  // Word index with upper address bits wrapping
  assign idx = i_req.req.addr[MEM_AW+1:2];

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      for (int w = 0; w < WORDS; w++)
      begin
        mem[w] <= '0;
      end
    end
    else if (i_req.valid && i_req.req.write)
    begin
      for (int b = 0; b < soc_pkg::MASK_W; b++)
      begin
        if (i_req.req.wr_mask[b])
        begin
          mem[idx][8*b +: 8] <= i_req.req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= i_req.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req.valid)
    begin
      rsp_data <= i_req.req.write ? '0 : soc_pkg::apply_rd_mask(mem[idx], i_req.req.rd_mask);
    end
  end

  assign o_rsp = '{valid: rsp_valid, rsp: '{rdata: rsp_data, err: 1'b0}};

endmodule

`default_nettype wire

//--- io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  logic                clk,
  input  logic                i_arst_n,
  input  soc_pkg::slave_req_t i_req,
  input  logic [1:0]          i_keys,
  input  logic [3:0]          i_switches,
  output logic [7:0]          o_led,
  output soc_pkg::slave_rsp_t o_rsp
);

  logic [1:0]                 keys_meta;
  logic [1:0]                 keys_sync;
  logic [3:0]                 sw_meta;
  logic [3:0]                 sw_sync;
  logic [7:0]                 led_q;
  logic [soc_pkg::ADDR_W-3:0] offset;
  logic                       hit_led;
  logic                       hit_keys;
  logic [soc_pkg::DATA_W-1:0] rd_word;
  logic                       rsp_valid;
  logic                       rsp_err;
  logic [soc_pkg::DATA_W-1:0] rsp_data;

  assign offset   = i_req.req.addr[soc_pkg::ADDR_W-3:0];
  assign hit_led  = (offset == soc_pkg::LED_OFFSET);
  assign hit_keys = (offset == soc_pkg::KEYS_OFFSET);

  always_comb
  begin
    if (hit_led)
      rd_word = soc_pkg::DATA_W'(led_q);
    else if (hit_keys)
      rd_word = soc_pkg::DATA_W'({sw_sync, keys_sync});
    else
      rd_word = '0;
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      keys_meta <= '0;
      keys_sync <= '0;
      sw_meta   <= '0;
      sw_sync   <= '0;
      led_q     <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      keys_meta <= i_keys;
      keys_sync <= keys_meta;
      sw_meta   <= i_switches;
      sw_sync   <= sw_meta;
      rsp_valid <= i_req.valid;
      // LED takes only byte lane 0
      if (i_req.valid && i_req.req.write && hit_led && i_req.req.wr_mask[0])
      begin
        led_q <= i_req.req.wdata[7:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req.valid)
    begin
      rsp_err  <= !(hit_led || hit_keys);
      rsp_data <= i_req.req.write ? '0 : soc_pkg::apply_rd_mask(rd_word, i_req.req.rd_mask);
    end
  end

  assign o_led = led_q;
  assign o_rsp = '{valid: rsp_valid, rsp: '{rdata: rsp_data, err: rsp_err}};

endmodule

`default_nettype wire

//--- resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module resp_merge #(
  parameter int RSP_DEPTH   = 4,
  parameter int RSP_CREDITS = 2
) (
  input  logic                clk,
  input  logic                i_arst_n,
  input  soc_pkg::slave_rsp_t i_mem_rsp,
  input  soc_pkg::slave_rsp_t i_io_rsp,
  input  logic                i_dispatch,
  input  logic                i_rsp_credit,
  output logic                o_slot_free,
  output logic                o_rsp_valid,
  output soc_pkg::bus_rsp_t   o_rsp
);

  localparam int RW = $clog2(RSP_DEPTH + 1);
  localparam int KW = $clog2(RSP_CREDITS + 1);

  soc_pkg::bus_rsp_t in_rsp;
  logic              in_push;
  logic              q_empty;
  logic              rsp_pop;
  logic [RW-1:0]     reserved_q;
  logic [KW-1:0]     credits_q;

  // Same slave latency, so at most one response per cycle
  always_comb
  begin
    in_push = i_mem_rsp.valid || i_io_rsp.valid;
    in_rsp  = i_mem_rsp.valid ? i_mem_rsp.rsp : i_io_rsp.rsp;
  end

  sync_fifo #(
    .T     (soc_pkg::bus_rsp_t),
    .DEPTH (RSP_DEPTH)
  ) rsp_fifo0 (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (in_push),
    .i_data   (in_rsp),
    .i_pop    (rsp_pop),
    .o_data   (o_rsp),
    .o_empty  (q_empty),
    .o_full   ()
  );

  assign rsp_pop     = !q_empty && (credits_q != '0);
  assign o_rsp_valid = rsp_pop;
  // Reserved covers in-flight dispatches and queued responses
  assign o_slot_free = (reserved_q < RW'(RSP_DEPTH));

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      reserved_q <= '0;
      credits_q  <= KW'(RSP_CREDITS);
    end
    else
    begin
      reserved_q <= reserved_q + RW'(i_dispatch) - RW'(rsp_pop);
      credits_q  <= credits_q + KW'(i_rsp_credit) - KW'(rsp_pop);
    end
  end

  a_single_rsp: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_mem_rsp.valid && i_io_rsp.valid))
    else $error("resp_merge: two slave responses in one cycle");

  a_rsp_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_dispatch |=> in_push)
    else $error("resp_merge: slave missed its one-cycle response");

  a_credit_max: assert property (@(posedge clk) disable iff (!i_arst_n)
    credits_q <= KW'(RSP_CREDITS))
    else $error("resp_merge: more response credits returned than issued");

endmodule

`default_nettype wire

//--- soc_fabric.f
+incdir+.
soc_pkg.sv
sync_fifo.sv
bus_decoder.sv
data_mem.sv
io_regs.sv
resp_merge.sv
soc_fabric.sv
tb_soc_fabric.sv

//--- soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric #(
  parameter int REQ_DEPTH   = 4,
  parameter int RSP_DEPTH   = 4,
  parameter int MEM_AW      = 8,
  parameter int RSP_CREDITS = 2
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_req_valid,
  input  soc_pkg::bus_req_t i_req,
  output logic              o_req_credit,
  output logic              o_rsp_valid,
  output soc_pkg::bus_rsp_t o_rsp,
  input  logic              i_rsp_credit,
  input  logic [1:0]        i_keys,
  input  logic [3:0]        i_switches,
  output logic [7:0]        o_led
);

  soc_pkg::bus_req_t   req_head;
  logic                req_empty;
  logic                slot_free;
  soc_pkg::slave_req_t mem_req;
  soc_pkg::slave_req_t io_req;
  soc_pkg::slave_rsp_t mem_rsp;
  soc_pkg::slave_rsp_t io_rsp;

  // Each pop frees a queue entry, returned to the requester as a credit
  sync_fifo #(
    .T     (soc_pkg::bus_req_t),
    .DEPTH (REQ_DEPTH)
  ) req_fifo0 (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (i_req_valid),
    .i_data   (i_req),
    .i_pop    (o_req_credit),
    .o_data   (req_head),
    .o_empty  (req_empty),
    .o_full   ()
  );

  bus_decoder decoder0 (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_req       (req_head),
    .i_req_empty (req_empty),
    .i_slot_free (slot_free),
    .o_pop       (o_req_credit),
    .o_mem_req   (mem_req),
    .o_io_req    (io_req)
  );

  data_mem #(.MEM_AW(MEM_AW)) mem0 (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_req    (mem_req),
    .o_rsp    (mem_rsp)
  );

  io_regs io0 (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_req      (io_req),
    .i_keys     (i_keys),
    .i_switches (i_switches),
    .o_led      (o_led),
    .o_rsp      (io_rsp)
  );

  resp_merge #(
    .RSP_DEPTH   (RSP_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
  ) merge0 (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_mem_rsp    (mem_rsp),
    .i_io_rsp     (io_rsp),
    .i_dispatch   (o_req_credit),
    .i_rsp_credit (i_rsp_credit),
    .o_slot_free  (slot_free),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp)
  );

endmodule

`default_nettype wire

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;

  // Top two address bits select the I/O block
  localparam logic [1:0] IO_REGION = 2'b11;

  // Byte offsets of the I/O registers inside the region
  localparam logic [ADDR_W-3:0] LED_OFFSET  = '0;
  localparam logic [ADDR_W-3:0] KEYS_OFFSET = (ADDR_W-2)'(4);

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] rd_mask;
    logic [MASK_W-1:0] wr_mask;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  typedef struct packed {
    logic     valid;
    bus_req_t req;
  } slave_req_t;

  typedef struct packed {
    logic     valid;
    bus_rsp_t rsp;
  } slave_rsp_t;

  // Zero the byte lanes not selected by the read mask
  function automatic logic [DATA_W-1:0] apply_rd_mask(input logic [DATA_W-1:0] data,
                                                      input logic [MASK_W-1:0] mask);
    logic [DATA_W-1:0] res;
    for (int b = 0; b < MASK_W; b++)
    begin
      res[8*b +: 8] = mask[b] ? data[8*b +: 8] : 8'h00;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_full
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (i_push)
    begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_push)
      begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop)
      begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(i_push) - CW'(i_pop);
    end
  end

  assign o_data  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_full  = (count == CW'(DEPTH));

  a_no_overflow: assert property (@(posedge clk) disable iff (!i_arst_n) i_push |-> !o_full)
    else $error("sync_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!i_arst_n) i_pop |-> !o_empty)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

//--- tb_fabric_model.svh
`ifndef TB_FABRIC_MODEL_SVH
`define TB_FABRIC_MODEL_SVH

// Reference state sized for the default memory depth
localparam int MODEL_AW = 8;

logic [31:0] model_mem [2**MODEL_AW];
logic [7:0]  model_led;

function automatic void model_reset();
  for (int w = 0; w < 2**MODEL_AW; w++)
  begin
    model_mem[w] = '0;
  end
  model_led = '0;
endfunction

function automatic logic [31:0] keep_read_lanes(input logic [31:0] data,
                                                input logic [3:0]  mask);
  logic [31:0] res;
  res = '0;
  for (int b = 0; b < 4; b++)
  begin
    if (mask[b])
    begin
      res[8*b +: 8] = data[8*b +: 8];
    end
  end
  return res;
endfunction

// Applies one request to the model and returns the response it expects
function automatic soc_pkg::bus_rsp_t model_access(input soc_pkg::bus_req_t r,
                                                   input logic [1:0] keys,
                                                   input logic [3:0] sw);
  soc_pkg::bus_rsp_t   rsp;
  logic [MODEL_AW-1:0] idx;
  logic [29:0]         offset;
  rsp    = '0;
  idx    = r.addr[MODEL_AW+1:2];
  offset = r.addr[29:0];
  if (r.addr[31:30] != 2'b11)
  begin
    for (int b = 0; b < 4; b++)
    begin
      if (r.write && r.wr_mask[b])
      begin
        model_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
      end
    end
    if (!r.write)
    begin
      rsp.rdata = keep_read_lanes(model_mem[idx], r.rd_mask);
    end
  end
  else if (offset == 30'd0)
  begin
    if (r.write && r.wr_mask[0])
    begin
      model_led = r.wdata[7:0];
    end
    if (!r.write)
    begin
      rsp.rdata = keep_read_lanes({24'h0, model_led}, r.rd_mask);
    end
  end
  else if (offset == 30'd4)
  begin
    if (!r.write)
    begin
      rsp.rdata = keep_read_lanes({26'h0, sw, keys}, r.rd_mask);
    end
  end
  else
  begin
    rsp.err = 1'b1;
  end
  return rsp;
endfunction

`endif

//--- tb_soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric;

  localparam int REQ_DEPTH   = 4;
  localparam int RSP_DEPTH   = 4;
  localparam int RSP_CREDITS = 2;
  localparam int N_DIRECTED  = 6;
  localparam int N_RANDOM    = 400;
  localparam int N_HOLD      = REQ_DEPTH + RSP_DEPTH + RSP_CREDITS;
  localparam int MAX_CYCLES  = 40 * (N_DIRECTED + N_RANDOM + N_HOLD) + 200;

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  soc_pkg::bus_req_t req;
  logic              req_credit;
  logic              rsp_valid;
  soc_pkg::bus_rsp_t rsp;
  logic              rsp_credit;
  logic [1:0]        keys;
  logic [3:0]        switches;
  logic [7:0]        led;

  int                seed = 85856;
  int                cycles;
  int                error_count;
  int                req_credits;
  int                credits_back;
  int                sent_total;
  int                rsp_owed;
  int                rsps_seen;
  int                hold_start;
  int                hold_len;
  logic              hold_credits;
  logic              sent;
  logic [1:0]        key_val;
  logic [3:0]        sw_val;
  logic [31:0]       rnd;
  soc_pkg::bus_rsp_t exp_q [$];

  `include "tb_fabric_model.svh"

  soc_fabric dut0 (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_req_valid  (req_valid),
    .i_req        (req),
    .o_req_credit (req_credit),
    .o_rsp_valid  (rsp_valid),
    .o_rsp        (rsp),
    .i_rsp_credit (rsp_credit),
    .i_keys       (keys),
    .i_switches   (switches),
    .o_led        (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
    begin
      error_count++;
      $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, expected);
      abort_run();
    end
  endtask

  function automatic soc_pkg::bus_req_t random_req();
    soc_pkg::bus_req_t r;
    logic [31:0]       pick;
    pick      = $random(seed);
    r.write   = pick[0];
    r.rd_mask = pick[7:4];
    r.wr_mask = pick[11:8];
    r.wdata   = $random(seed);
    r.addr    = $random(seed);
    if (pick[15:14] == 2'b00)
    begin
      r.addr[31:30] = 2'b11;
      if (pick[17:16] == 2'b00)
      begin
        r.addr[29:0] = 30'd0;
      end
      else if (pick[17:16] == 2'b01)
      begin
        r.addr[29:0] = 30'd4;
      end
      else if (r.addr[29:0] == 30'd0 || r.addr[29:0] == 30'd4)
      begin
        r.addr[29:0] = 30'd8;
      end
    end
    else
    begin
      // Few words so reads hit earlier writes and upper bits wrap
      r.addr[9:6] = 4'b0000;
      if (r.addr[31:30] == 2'b11)
      begin
        r.addr[31] = 1'b0;
      end
    end
    return r;
  endfunction

  // Observe outputs at one clock edge and then drive the next inputs
  task automatic step(input logic do_send, input soc_pkg::bus_req_t r, output logic was_sent);
    soc_pkg::bus_rsp_t expected;
    logic [31:0]       coin;
    @(posedge clk);
    coin = $random(seed);
    if (req_credit)
    begin
      req_credits++;
      credits_back++;
    end
    if (rsp_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Response arrived at time %0t with no request outstanding", $time);
        abort_run();
      end
      else
      begin
        expected = exp_q.pop_front();
        check_value("o_rsp.rdata", 64'(rsp.rdata), 64'(expected.rdata));
        check_value("o_rsp.err", 64'(rsp.err), 64'(expected.err));
        rsp_owed++;
        rsps_seen++;
      end
    end
    req_valid  <= 1'b0;
    rsp_credit <= 1'b0;
    was_sent   = 1'b0;
    if (!hold_credits && rsp_owed > 0 && coin[1:0] == 2'b00)
    begin
      rsp_credit <= 1'b1;
      rsp_owed--;
    end
    if (do_send && req_credits > 0)
    begin
      req_valid <= 1'b1;
      req       <= r;
      req_credits--;
      sent_total++;
      exp_q.push_back(model_access(r, key_val, sw_val));
      was_sent = 1'b1;
    end
  endtask

  task automatic send_wait(input soc_pkg::bus_req_t r);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      step(1'b1, r, done);
    end
  endtask

  task automatic drain();
    logic unused;
    while (exp_q.size() != 0 || rsp_owed != 0)
    begin
      step(1'b0, '0, unused);
    end
    step(1'b0, '0, unused);
  endtask

  // Inputs move only with nothing outstanding, then settle
  task automatic set_inputs(input logic [1:0] k, input logic [3:0] s);
    logic unused;
    drain();
    step(1'b0, '0, unused);
    keys     <= k;
    switches <= s;
    key_val  = k;
    sw_val   = s;
    repeat (4) step(1'b0, '0, unused);
    check_value("o_led", 64'(led), 64'(model_led));
  endtask

  initial
  begin
    arst_n       = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    rsp_credit   = 1'b0;
    keys         = '0;
    switches     = '0;
    key_val      = '0;
    sw_val       = '0;
    hold_credits = 1'b0;
    req_credits  = REQ_DEPTH;
    model_reset();
    repeat (10) @(posedge clk);
    check_value("o_req_credit", 64'(req_credit), 64'(0));
    check_value("o_rsp_valid", 64'(rsp_valid), 64'(0));
    check_value("o_led", 64'(led), 64'(0));
    arst_n <= 1'b1;

    set_inputs(2'b10, 4'b1011);
    send_wait('{write: 1'b1, addr: 32'hC000_0000, wdata: 32'h1234_565A,
                rd_mask: 4'h0, wr_mask: 4'b0001});
    send_wait('{write: 1'b0, addr: 32'hC000_0000, wdata: 32'h0, rd_mask: 4'hF, wr_mask: 4'h0});
    send_wait('{write: 1'b0, addr: 32'hC000_0004, wdata: 32'h0, rd_mask: 4'hF, wr_mask: 4'h0});
    send_wait('{write: 1'b0, addr: 32'hC000_0010, wdata: 32'h0, rd_mask: 4'hF, wr_mask: 4'h0});
    send_wait('{write: 1'b1, addr: 32'h0000_000C, wdata: 32'hDEAD_BEEF,
                rd_mask: 4'h0, wr_mask: 4'b0110});
    // Same word through the wrapped address
    send_wait('{write: 1'b0, addr: 32'h0000_040C, wdata: 32'h0, rd_mask: 4'b1110, wr_mask: 4'h0});
    drain();
    check_value("o_led", 64'(led), 64'(model_led));

    for (int blk = 0; blk < 8; blk++)
    begin
      rnd = $random(seed);
      set_inputs(rnd[1:0], rnd[5:2]);
      for (int n = 0; n < N_RANDOM / 8; n++)
      begin
        send_wait(random_req());
      end
    end
    drain();

    // Withhold response credits until back-pressure reaches the requester
    hold_credits = 1'b1;
    hold_start   = rsps_seen;
    rnd          = $random(seed);
    hold_len     = 60 + int'(rnd[5:0]);
    repeat (hold_len) step(1'b1, random_req(), sent);
    check_value("responses_during_hold", 64'(rsps_seen - hold_start), 64'(RSP_CREDITS));
    check_value("queued_requests", 64'(exp_q.size()), 64'(REQ_DEPTH + RSP_DEPTH));
    check_value("req_credits", 64'(req_credits), 64'(0));
    hold_credits = 1'b0;
    drain();

    check_value("credits_returned", 64'(credits_back), 64'(sent_total));
    if (error_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
